// File: sim.f
src/eth_pkg.sv
src/eth_axis_tx.sv
src/eth_axis_rx.sv
src/eth_loopback_top.sv
dv/eth_loopback_tb.sv

// File: Bender.yml
package:
  name: eth_loopback

sources:
  - files:
      - src/eth_pkg.sv
      - src/eth_axis_tx.sv
      - src/eth_axis_rx.sv
      - src/eth_loopback_top.sv
  - target: simulation
    files:
      - dv/eth_loopback_tb.sv

// File: dv/eth_loopback_tb.sv
// loopback testbench: clock, reset, random frame stimulus, scoreboard queues, assertions, report

`timescale 1ns/1ps

module eth_loopback_tb;

    localparam int CLK_HALF       = 20;
    localparam int DRIVE_DELAY    = 1;
    localparam int SEED           = 96;
    localparam int NUM_FRAMES     = 24;
    localparam int TIMEOUT_CYCLES = 60 * NUM_FRAMES + 200;

    logic        clk;
    logic        rst;
    logic        s_hdr_valid;
    logic        s_hdr_ready;
    logic [47:0] s_dest_mac;
    logic [47:0] s_src_mac;
    logic [15:0] s_type;
    logic [7:0]  s_tdata;
    logic        s_tvalid;
    logic        s_tready;
    logic        s_tlast;
    logic        s_tuser;
    logic        m_hdr_valid;
    logic        m_hdr_ready;
    logic [47:0] m_dest_mac;
    logic [47:0] m_src_mac;
    logic [15:0] m_type;
    logic [7:0]  m_tdata;
    logic        m_tvalid;
    logic        m_tready;
    logic        m_tlast;
    logic        m_tuser;
    logic        tx_busy;
    logic        rx_busy;

    // expected headers as {dest, src, type}, bytes as {last, user, data}
    logic [111:0] hdr_q[$];
    logic [9:0]   byte_q[$];

    int value_errors    = 0;
    int protocol_errors = 0;
    int cycle_count     = 0;
    bit random_ready    = 1'b0;

    eth_loopback_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp) else begin
            value_errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_header();
        logic [111:0] exp;
        if (hdr_q.size() == 0) begin
            protocol_errors++;
            $display("header came out with no frame expected");
        end else begin
            exp = hdr_q.pop_front();
            check_value("m_dest_mac", 64'(m_dest_mac), 64'(exp[111:64]));
            check_value("m_src_mac", 64'(m_src_mac), 64'(exp[63:16]));
            check_value("m_type", 64'(m_type), 64'(exp[15:0]));
        end
    endtask

    task automatic check_byte();
        logic [9:0] exp;
        if (byte_q.size() == 0) begin
            protocol_errors++;
            $display("payload byte came out with no byte expected");
        end else begin
            exp = byte_q.pop_front();
            check_value("m_tdata", 64'(m_tdata), 64'(exp[7:0]));
            check_value("m_tlast", 64'(m_tlast), 64'(exp[9]));
            // user only means something on the last byte
            if (exp[9]) begin
                check_value("m_tuser", 64'(m_tuser), 64'(exp[8]));
            end
        end
    endtask

    // outputs sampled at the edge where the transfer happens
    always @(posedge clk) begin
        if (!rst) begin
            if (m_hdr_valid && m_hdr_ready) begin
                check_header();
            end
            if (m_tvalid && m_tready) begin
                check_byte();
            end
        end
    end

    hdr_stable: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_dest_mac)
            && $stable(m_src_mac) && $stable(m_type))
        else begin
            protocol_errors++;
            $display("header output dropped or changed while waiting");
        end

    pay_stable: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
            && $stable(m_tuser))
        else begin
            protocol_errors++;
            $display("payload output dropped or changed while stalled");
        end

    // sink readies, always high in the first half of the run
    task automatic drive_sink_readies();
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (random_ready) begin
                m_tready    = ($urandom() % 4) != 0;
                m_hdr_ready = ($urandom() % 4) != 0;
            end else begin
                m_tready    = 1'b1;
                m_hdr_ready = 1'b1;
            end
        end
    endtask

    task automatic check_quiet_after_reset();
        bit saw_ready;
        saw_ready = 1'b0;
        repeat (4) begin
            @(posedge clk);
            check_value("m_tvalid", 64'(m_tvalid), 64'd0);
            check_value("m_hdr_valid", 64'(m_hdr_valid), 64'd0);
            check_value("tx_busy", 64'(tx_busy), 64'd0);
            check_value("rx_busy", 64'(rx_busy), 64'd0);
            if (s_hdr_ready) begin
                saw_ready = 1'b1;
            end
        end
        assert (saw_ready) else begin
            protocol_errors++;
            $display("s_hdr_ready never rose after reset");
        end
        #DRIVE_DELAY;
    endtask

    // entered and left a short delay after a rising edge
    task automatic send_frame(input bit gaps);
        logic [111:0] hdr;
        int           len;
        logic         user;
        logic [7:0]   data;
        hdr  = 112'({$urandom(), $urandom(), $urandom(), $urandom()});
        len  = $urandom_range(40, 1);
        user = 1'($urandom());

        s_hdr_valid = 1'b1;
        s_dest_mac  = hdr[111:64];
        s_src_mac   = hdr[63:16];
        s_type      = hdr[15:0];
        hdr_q.push_back(hdr);
        do @(posedge clk); while (!s_hdr_ready);
        #DRIVE_DELAY;
        s_hdr_valid = 1'b0;

        for (int i = 0; i < len; i++) begin
            if (gaps && ($urandom() % 8) == 0) begin
                s_tvalid = 1'b0;
                @(posedge clk);
                #DRIVE_DELAY;
            end
            data     = 8'($urandom());
            s_tdata  = data;
            s_tvalid = 1'b1;
            s_tlast  = (i == len - 1);
            s_tuser  = (i == len - 1) ? user : 1'b0;
            byte_q.push_back({s_tlast, s_tuser, data});
            do @(posedge clk); while (!s_tready);
            #DRIVE_DELAY;
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        s_tuser  = 1'b0;
    endtask

    task automatic report();
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    endtask

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        s_hdr_valid = 1'b0;
        s_dest_mac  = '0;
        s_src_mac   = '0;
        s_type      = '0;
        s_tdata     = '0;
        s_tvalid    = 1'b0;
        s_tlast     = 1'b0;
        s_tuser     = 1'b0;
        m_tready    = 1'b0;
        m_hdr_ready = 1'b0;

        fork
            drive_sink_readies();
        join_none

        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        check_quiet_after_reset();

        for (int f = 0; f < NUM_FRAMES; f++) begin
            random_ready = (f >= NUM_FRAMES / 2);
            send_frame(random_ready);
        end

        // let the receiver drain everything still in flight
        while (hdr_q.size() != 0 || byte_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        check_value("tx_busy", 64'(tx_busy), 64'd0);
        check_value("rx_busy", 64'(rx_busy), 64'd0);

        report();
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        protocol_errors++;
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report();
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: src/eth_loopback_top.sv
// loopback top level: frame transmitter feeding frame receiver over a byte link

`timescale 1ns/1ps

module eth_loopback_top (
    input  logic        clk,
    input  logic        rst,

    // header into tx
    input  logic        s_hdr_valid,
    output logic        s_hdr_ready,
    input  logic [47:0] s_dest_mac,
    input  logic [47:0] s_src_mac,
    input  logic [15:0] s_type,

    // payload into tx
    input  logic [7:0]  s_tdata,
    input  logic        s_tvalid,
    output logic        s_tready,
    input  logic        s_tlast,
    input  logic        s_tuser,

    // header out of rx
    output logic        m_hdr_valid,
    input  logic        m_hdr_ready,
    output logic [47:0] m_dest_mac,
    output logic [47:0] m_src_mac,
    output logic [15:0] m_type,

    // payload out of rx
    output logic [7:0]  m_tdata,
    output logic        m_tvalid,
    input  logic        m_tready,
    output logic        m_tlast,
    output logic        m_tuser,

    output logic        tx_busy,
    output logic        rx_busy
);

    // internal byte link
    logic [7:0] link_tdata;
    logic       link_tvalid;
    logic       link_tready;
    logic       link_tlast;
    logic       link_tuser;

    eth_axis_tx tx_i (
        .clk         (clk),
        .rst         (rst),
        .s_hdr_valid (s_hdr_valid),
        .s_hdr_ready (s_hdr_ready),
        .s_dest_mac  (s_dest_mac),
        .s_src_mac   (s_src_mac),
        .s_type      (s_type),
        .s_tdata     (s_tdata),
        .s_tvalid    (s_tvalid),
        .s_tready    (s_tready),
        .s_tlast     (s_tlast),
        .s_tuser     (s_tuser),
        .m_tdata     (link_tdata),
        .m_tvalid    (link_tvalid),
        .m_tready    (link_tready),
        .m_tlast     (link_tlast),
        .m_tuser     (link_tuser),
        .busy        (tx_busy)
    );

    eth_axis_rx rx_i (
        .clk         (clk),
        .rst         (rst),
        .s_tdata     (link_tdata),
        .s_tvalid    (link_tvalid),
        .s_tready    (link_tready),
        .s_tlast     (link_tlast),
        .s_tuser     (link_tuser),
        .m_hdr_valid (m_hdr_valid),
        .m_hdr_ready (m_hdr_ready),
        .m_dest_mac  (m_dest_mac),
        .m_src_mac   (m_src_mac),
        .m_type      (m_type),
        .m_tdata     (m_tdata),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tlast     (m_tlast),
        .m_tuser     (m_tuser),
        .busy        (rx_busy)
    );

endmodule

// File: src/eth_axis_rx.sv
// ethernet frame receiver: byte stream to header fields plus payload stream

`timescale 1ns/1ps

module eth_axis_rx import eth_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // frame in
    input  logic [7:0]  s_tdata,
    input  logic        s_tvalid,
    output logic        s_tready,
    input  logic        s_tlast,
    input  logic        s_tuser,

    // header out
    output logic        m_hdr_valid,
    input  logic        m_hdr_ready,
    output logic [47:0] m_dest_mac,
    output logic [47:0] m_src_mac,
    output logic [15:0] m_type,

    // payload out
    output logic [7:0]  m_tdata,
    output logic        m_tvalid,
    input  logic        m_tready,
    output logic        m_tlast,
    output logic        m_tuser,

    output logic        busy
);

    logic [1:0]           state;
    logic [HDR_PTR_W-1:0] hdr_ptr;
    eth_hdr_t             hdr_sr;
    logic                 hdr_valid_reg;

    logic [7:0] pay_tdata;
    logic       pay_tvalid;
    logic       pay_tlast;
    logic       pay_tuser;
    logic       busy_reg;

    logic link_xfer;
    logic hdr_xfer;
    logic pay_xfer;

    // link ready from registered state and sink ready only
    always_comb begin
        case (state)
            RX_HDR:     s_tready = !hdr_valid_reg;
            RX_PAYLOAD: s_tready = !pay_tvalid || m_tready;
            default:    s_tready = 1'b0;
        endcase
    end

    assign link_xfer = s_tvalid && s_tready;
    assign hdr_xfer  = link_xfer && (state == RX_HDR);
    assign pay_xfer  = link_xfer && (state == RX_PAYLOAD);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= RX_INIT;
            hdr_ptr       <= '0;
            hdr_valid_reg <= 1'b0;
            pay_tvalid    <= 1'b0;
            busy_reg      <= 1'b0;
        end else begin
            if (m_hdr_ready) begin
                hdr_valid_reg <= 1'b0;
            end

            case (state)
                RX_INIT: begin
                    state <= RX_HDR;
                end
                RX_HDR: begin
                    if (hdr_xfer) begin
                        busy_reg <= 1'b1;
                        if (hdr_ptr == HDR_LAST_PTR) begin
                            // full header collected
                            hdr_ptr       <= '0;
                            hdr_valid_reg <= 1'b1;
                            state         <= RX_PAYLOAD;
                        end else begin
                            hdr_ptr <= hdr_ptr + 1'b1;
                        end
                    end
                end
                RX_PAYLOAD: begin
                    if (pay_xfer && s_tlast) begin
                        busy_reg <= 1'b0;
                        state    <= RX_HDR;
                    end
                end
                default: begin
                    state <= RX_INIT;
                end
            endcase

            // single output slot, refilled in the cycle it drains
            if (pay_xfer) begin
                pay_tvalid <= 1'b1;
            end else if (m_tready) begin
                pay_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            hdr_sr.b <= {hdr_sr.b[ETH_HDR_BYTES-2:0], s_tdata};
        end
        if (pay_xfer) begin
            pay_tdata <= s_tdata;
            pay_tlast <= s_tlast;
            pay_tuser <= s_tuser;
        end
    end

    assign m_hdr_valid = hdr_valid_reg;
    assign m_dest_mac  = hdr_sr.f.dest_mac;
    assign m_src_mac   = hdr_sr.f.src_mac;
    assign m_type      = hdr_sr.f.eth_type;

    assign m_tdata  = pay_tdata;
    assign m_tvalid = pay_tvalid;
    assign m_tlast  = pay_tlast;
    assign m_tuser  = pay_tuser;
    assign busy     = busy_reg;

    // shift register frozen while the header waits
    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_dest_mac)
            && $stable(m_src_mac) && $stable(m_type));

    // stalled payload byte held
    pay_hold: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
            && $stable(m_tuser));

endmodule

// File: src/eth_axis_tx.sv
// ethernet frame transmitter: header fields plus payload stream to one byte stream

`timescale 1ns/1ps

module eth_axis_tx import eth_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // header in
    input  logic        s_hdr_valid,
    output logic        s_hdr_ready,
    input  logic [47:0] s_dest_mac,
    input  logic [47:0] s_src_mac,
    input  logic [15:0] s_type,

    // payload in
    input  logic [7:0]  s_tdata,
    input  logic        s_tvalid,
    output logic        s_tready,
    input  logic        s_tlast,
    input  logic        s_tuser,

    // frame out
    output logic [7:0]  m_tdata,
    output logic        m_tvalid,
    input  logic        m_tready,
    output logic        m_tlast,
    output logic        m_tuser,

    output logic        busy
);

    logic [1:0]           state;
    logic [1:0]           state_next;
    logic [HDR_PTR_W-1:0] hdr_ptr;
    logic [HDR_PTR_W-1:0] hdr_ptr_next;
    logic                 store_hdr;

    eth_hdr_t hdr_in;
    eth_hdr_t hdr_reg;

    logic s_hdr_ready_reg;
    logic s_hdr_ready_next;
    logic s_tready_reg;
    logic s_tready_next;
    logic busy_reg;

    // byte headed into the skid stage
    logic [7:0] int_tdata;
    logic       int_tvalid;
    logic       int_tlast;
    logic       int_tuser;
    logic       int_tready_reg;
    logic       int_tready_early;

    // skid stage
    logic [7:0] out_tdata;
    logic       out_tvalid;
    logic       out_tvalid_next;
    logic       out_tlast;
    logic       out_tuser;
    logic [7:0] tmp_tdata;
    logic       tmp_tvalid;
    logic       tmp_tvalid_next;
    logic       tmp_tlast;
    logic       tmp_tuser;
    logic       int_to_out;
    logic       int_to_tmp;
    logic       tmp_to_out;

    assign hdr_in.f.dest_mac = s_dest_mac;
    assign hdr_in.f.src_mac  = s_src_mac;
    assign hdr_in.f.eth_type = s_type;

    assign s_hdr_ready = s_hdr_ready_reg;
    assign s_tready    = s_tready_reg;
    assign busy        = busy_reg;

    always_comb begin
        state_next       = state;
        hdr_ptr_next     = hdr_ptr;
        store_hdr        = 1'b0;
        s_hdr_ready_next = 1'b0;
        s_tready_next    = 1'b0;
        int_tdata        = 8'd0;
        int_tvalid       = 1'b0;
        int_tlast        = 1'b0;
        int_tuser        = 1'b0;

        case (state)
            TX_IDLE: begin
                hdr_ptr_next     = '0;
                s_hdr_ready_next = 1'b1;
                if (s_hdr_valid && s_hdr_ready) begin
                    store_hdr        = 1'b1;
                    s_hdr_ready_next = 1'b0;
                    state_next       = TX_HDR;
                    // first byte straight from the inputs if there is room
                    if (int_tready_reg) begin
                        int_tvalid   = 1'b1;
                        int_tdata    = hdr_in.b[HDR_FIRST_BYTE];
                        hdr_ptr_next = HDR_PTR_W'(1);
                    end
                end
            end
            TX_HDR: begin
                if (int_tready_reg) begin
                    int_tvalid   = 1'b1;
                    int_tdata    = hdr_reg.b[HDR_LAST_PTR - hdr_ptr];
                    hdr_ptr_next = hdr_ptr + 1'b1;
                    if (hdr_ptr == HDR_LAST_PTR) begin
                        s_tready_next = int_tready_early;
                        state_next    = TX_PAYLOAD;
                    end
                end
            end
            TX_PAYLOAD: begin
                s_tready_next = int_tready_early;
                int_tdata     = s_tdata;
                int_tvalid    = s_tvalid;
                int_tlast     = s_tlast;
                int_tuser     = s_tuser;
                if (s_tvalid && s_tready && s_tlast) begin
                    s_tready_next    = 1'b0;
                    s_hdr_ready_next = 1'b1;
                    state_next       = TX_IDLE;
                end
            end
            default: begin
                state_next = TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= TX_IDLE;
            hdr_ptr         <= '0;
            s_hdr_ready_reg <= 1'b0;
            s_tready_reg    <= 1'b0;
            busy_reg        <= 1'b0;
        end else begin
            state           <= state_next;
            hdr_ptr         <= hdr_ptr_next;
            s_hdr_ready_reg <= s_hdr_ready_next;
            s_tready_reg    <= s_tready_next;
            busy_reg        <= (state_next != TX_IDLE);
        end
    end

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            hdr_reg <= hdr_in;
        end
    end

    // room next cycle unless the temp register would be filled
    assign int_tready_early = m_tready || (!tmp_tvalid && (!out_tvalid || !int_tvalid));

    always_comb begin
        out_tvalid_next = out_tvalid;
        tmp_tvalid_next = tmp_tvalid;
        int_to_out      = 1'b0;
        int_to_tmp      = 1'b0;
        tmp_to_out      = 1'b0;

        if (int_tready_reg) begin
            if (m_tready || !out_tvalid) begin
                out_tvalid_next = int_tvalid;
                int_to_out      = 1'b1;
            end else begin
                // sink stalled, park the byte
                tmp_tvalid_next = int_tvalid;
                int_to_tmp      = 1'b1;
            end
        end else if (m_tready) begin
            // drain the parked byte
            out_tvalid_next = tmp_tvalid;
            tmp_tvalid_next = 1'b0;
            tmp_to_out      = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_tvalid     <= 1'b0;
            tmp_tvalid     <= 1'b0;
            int_tready_reg <= 1'b0;
        end else begin
            out_tvalid     <= out_tvalid_next;
            tmp_tvalid     <= tmp_tvalid_next;
            int_tready_reg <= int_tready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            out_tdata <= int_tdata;
            out_tlast <= int_tlast;
            out_tuser <= int_tuser;
        end else if (tmp_to_out) begin
            out_tdata <= tmp_tdata;
            out_tlast <= tmp_tlast;
            out_tuser <= tmp_tuser;
        end
        if (int_to_tmp) begin
            tmp_tdata <= int_tdata;
            tmp_tlast <= int_tlast;
            tmp_tuser <= int_tuser;
        end
    end

    assign m_tdata  = out_tdata;
    assign m_tvalid = out_tvalid;
    assign m_tlast  = out_tlast;
    assign m_tuser  = out_tuser;

    // a stalled byte stays put until the sink takes it
    out_hold: assert property (@(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
            && $stable(m_tuser));

    // header and payload are never open at once
    ready_excl: assert property (@(posedge clk) disable iff (rst)
        !(s_hdr_ready && s_tready));

endmodule

// File: src/eth_pkg.sv
// ethernet header union, header length and byte-index constants, FSM state codes

package eth_pkg;

    // header length on the wire, in bytes
    localparam int ETH_HDR_BYTES = 14;

    // header byte counter width, tx and rx
    localparam int HDR_PTR_W = 4;

    // counter value of the final header byte
    localparam logic [HDR_PTR_W-1:0] HDR_LAST_PTR = HDR_PTR_W'(ETH_HDR_BYTES - 1);

    // byte-view index of the first byte on the wire (top of dest_mac)
    localparam int HDR_FIRST_BYTE = ETH_HDR_BYTES - 1;

    // tx FSM states
    localparam logic [1:0] TX_IDLE = 2'd0;
    localparam logic [1:0] TX_HDR = 2'd1;
    localparam logic [1:0] TX_PAYLOAD = 2'd2;

    // rx FSM states
    localparam logic [1:0] RX_INIT = 2'd0;
    localparam logic [1:0] RX_HDR = 2'd1;
    localparam logic [1:0] RX_PAYLOAD = 2'd2;

    // header as named fields
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_fields_t;

    // same 112 bits as named fields or as wire bytes
    // byte 13 goes out first
    typedef union packed {
        eth_fields_t                    f;
        logic [ETH_HDR_BYTES-1:0][7:0]  b;
    } eth_hdr_t;

endpackage
